/* Bender.yml */
package:
  name: core_top

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/fetch_unit.sv
      - verilog/decode_unit.sv
      - verilog/register_file.sv
      - verilog/execute_unit.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_core_top.sv

/* tb.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/core_top.sv
test/tb_core_top.sv

/* test/tb_core_top.sv */
`timescale 1ns/100ps

`include "core_cfg.svh"

`default_nettype none

module tb_core_top;

    localparam int          PROG_LEN       = 64;
    localparam int          COMMIT_TIMEOUT = 200;
    localparam logic [15:0] LFSR_SEED      = 16'd42;

    logic                aclk = 1'b0;
    logic                aresetn;
    logic                i_ar_ready = 1'b0;
    logic                i_r_valid = 1'b0;
    core_pkg::word_t     i_r_data = '0;
    logic                o_ar_valid;
    core_pkg::addr_t     o_ar_addr;
    logic                o_r_ready;
    logic                o_commit_valid;
    core_pkg::addr_t     o_commit_pc;
    core_pkg::word_t     o_commit_inst;
    logic                o_commit_rf_wen;
    core_pkg::reg_addr_t o_commit_rf_wnum;
    core_pkg::word_t     o_commit_rf_wdata;

    logic [15:0]         lfsr_state = LFSR_SEED;
    core_pkg::word_t     prog [0:PROG_LEN-1];
    core_pkg::word_t     model_regs [0:31];

    // expected commit trace with one entry per retired instruction
    core_pkg::addr_t     exp_pc [$];
    core_pkg::word_t     exp_inst [$];
    logic                exp_wen [$];
    core_pkg::reg_addr_t exp_wnum [$];
    core_pkg::word_t     exp_wdata [$];
    core_pkg::addr_t     end_pc;

    // memory model state
    logic                resp_pending;
    core_pkg::addr_t     resp_addr;
    logic [1:0]          resp_delay;
    logic                first_req_seen;

    core_top dut (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .i_ar_ready        (i_ar_ready),
        .i_r_valid         (i_r_valid),
        .i_r_data          (i_r_data),
        .o_ar_valid        (o_ar_valid),
        .o_ar_addr         (o_ar_addr),
        .o_r_ready         (o_r_ready),
        .o_commit_valid    (o_commit_valid),
        .o_commit_pc       (o_commit_pc),
        .o_commit_inst     (o_commit_inst),
        .o_commit_rf_wen   (o_commit_rf_wen),
        .o_commit_rf_wnum  (o_commit_rf_wnum),
        .o_commit_rf_wdata (o_commit_rf_wdata)
    );

    always #20 aclk = ~aclk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic core_pkg::word_t mem_read(input core_pkg::addr_t addr);
        core_pkg::addr_t idx;
        idx = (addr - `CORE_RESET_PC) >> 2;
        if (addr >= `CORE_RESET_PC && idx < PROG_LEN) begin
            return prog[idx];
        end
        // undefined opcode mixing every address bit outside the program
        return {6'h3f, addr[31:6] ^ addr[25:0]};
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string what, input core_pkg::addr_t got,
                              input core_pkg::addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string what, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string what, input core_pkg::reg_addr_t got,
                             input core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // runs one instruction on the model register file and returns the next pc
    function automatic core_pkg::addr_t ref_execute(input core_pkg::addr_t pc,
                                                    input core_pkg::word_t inst,
                                                    output logic wen,
                                                    output core_pkg::reg_addr_t wnum,
                                                    output core_pkg::word_t wdata);
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     vj;
        core_pkg::word_t     vk;
        core_pkg::word_t     vd;
        core_pkg::word_t     res;
        core_pkg::addr_t     next_pc;
        logic                writes;
        rd      = inst[4:0];
        vj      = model_regs[inst[9:5]];
        vk      = model_regs[inst[14:10]];
        vd      = model_regs[rd];
        res     = '0;
        writes  = 1'b1;
        next_pc = pc + 32'd4;
        if (inst[31:26] == `CORE_OP_BEQ || inst[31:26] == `CORE_OP_BNE) begin
            writes = 1'b0;
            if ((vj == vd) == (inst[31:26] == `CORE_OP_BEQ)) begin
                next_pc = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
            end
        end else if (inst[31:26] == `CORE_OP_B) begin
            writes  = 1'b0;
            next_pc = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else if (inst[31:25] == `CORE_OP_LU12I_W) begin
            res = {inst[24:5], 12'h000};
        end else if (inst[31:22] == `CORE_OP_ADDI_W) begin
            res = vj + {{20{inst[21]}}, inst[21:10]};
        end else begin
            case (inst[31:15])
                `CORE_OP_ADD_W: res = vj + vk;
                `CORE_OP_SUB_W: res = vj - vk;
                `CORE_OP_AND:   res = vj & vk;
                `CORE_OP_OR:    res = vj | vk;
                `CORE_OP_XOR:   res = vj ^ vk;
                default:        writes = 1'b0;
            endcase
        end
        // r0 stays zero
        wen   = writes && (rd != '0);
        wnum  = rd;
        wdata = res;
        if (wen) begin
            model_regs[rd] = res;
        end
        return next_pc;
    endfunction

    task automatic build_program();
        int                  kind;
        int                  ahead;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rj;
        core_pkg::reg_addr_t rk;
        logic [19:0]         imm;
        logic [25:0]         offs;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind  = int'(rand_bits(4)) % 11;
            // few registers so that dependencies and r0 targets are common
            rd    = core_pkg::reg_addr_t'(rand_bits(3));
            rj    = core_pkg::reg_addr_t'(rand_bits(3));
            rk    = core_pkg::reg_addr_t'(rand_bits(3));
            imm   = 20'(rand_bits(20));
            // forward only and at most to the first word past the program
            ahead = 1 + int'(rand_bits(3)) % (PROG_LEN - i);
            offs  = ahead[25:0];
            case (kind)
                0:       prog[i] = {`CORE_OP_ADD_W, rk, rj, rd};
                1:       prog[i] = {`CORE_OP_SUB_W, rk, rj, rd};
                2:       prog[i] = {`CORE_OP_AND, rk, rj, rd};
                3:       prog[i] = {`CORE_OP_OR, rk, rj, rd};
                4:       prog[i] = {`CORE_OP_XOR, rk, rj, rd};
                5:       prog[i] = {`CORE_OP_ADDI_W, imm[11:0], rj, rd};
                6:       prog[i] = {`CORE_OP_LU12I_W, imm, rd};
                7:       prog[i] = {`CORE_OP_BEQ, offs[15:0], rj, rd};
                8:       prog[i] = {`CORE_OP_BNE, offs[15:0], rj, rd};
                9:       prog[i] = {`CORE_OP_B, offs[15:0], offs[25:16]};
                default: prog[i] = {6'h3f, rk, rj, rd, imm[10:0]};
            endcase
        end
    endtask

    task automatic build_trace();
        core_pkg::addr_t     pc;
        core_pkg::addr_t     next_pc;
        core_pkg::word_t     inst;
        logic                wen;
        core_pkg::reg_addr_t wnum;
        core_pkg::word_t     wdata;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        pc = `CORE_RESET_PC;
        while (((pc - `CORE_RESET_PC) >> 2) < PROG_LEN && exp_pc.size() < PROG_LEN) begin
            inst    = prog[(pc - `CORE_RESET_PC) >> 2];
            next_pc = ref_execute(pc, inst, wen, wnum, wdata);
            exp_pc.push_back(pc);
            exp_inst.push_back(inst);
            exp_wen.push_back(wen);
            exp_wnum.push_back(wnum);
            exp_wdata.push_back(wdata);
            pc = next_pc;
        end
        end_pc = pc;
    endtask

    task automatic wait_commit(input int index);
        int cycles;
        cycles = 0;
        do begin
            @(posedge aclk);
            cycles++;
            if (cycles > COMMIT_TIMEOUT) begin
                $display("timeout at %0t ns: core stopped committing, %0d of %0d retired",
                         $time, index, exp_pc.size());
                stop_on_error();
            end
        end while (!o_commit_valid);
    endtask

    // program memory with random ready and response delays
    always @(posedge aclk) begin
        if (!aresetn) begin
            i_ar_ready     <= 1'b0;
            i_r_valid      <= 1'b0;
            i_r_data       <= '0;
            resp_pending   <= 1'b0;
            resp_delay     <= '0;
            first_req_seen <= 1'b0;
        end else begin
            i_ar_ready <= (rand_bits(2) != 0);
            if (o_ar_valid && i_ar_ready) begin
                if (!first_req_seen) begin
                    check_addr("first fetch address", o_ar_addr, `CORE_RESET_PC);
                end
                first_req_seen <= 1'b1;
                resp_pending   <= 1'b1;
                resp_addr      <= o_ar_addr;
                resp_delay     <= 2'(rand_bits(2));
            end
            if (i_r_valid && o_r_ready) begin
                i_r_valid <= 1'b0;
            end
            if (resp_pending && !i_r_valid) begin
                if (resp_delay == 0) begin
                    i_r_valid    <= 1'b1;
                    i_r_data     <= mem_read(resp_addr);
                    resp_pending <= 1'b0;
                end else begin
                    resp_delay <= resp_delay - 2'd1;
                end
            end
        end
    end

    initial begin
        aresetn = 1'b0;
        build_program();
        build_trace();

        for (int i = 0; i < 10; i++) begin
            @(posedge aclk);
            if (i > 0) begin
                check_bit("o_commit_valid in reset", o_commit_valid, 1'b0);
                check_bit("o_ar_valid in reset", o_ar_valid, 1'b0);
                check_bit("o_r_ready in reset", o_r_ready, 1'b0);
            end
        end
        aresetn <= 1'b1;

        for (int n = 0; n < exp_pc.size(); n++) begin
            wait_commit(n);
            check_addr($sformatf("commit %0d pc", n), o_commit_pc, exp_pc[n]);
            check_word($sformatf("commit %0d inst", n), o_commit_inst, exp_inst[n]);
            check_bit($sformatf("commit %0d wen", n), o_commit_rf_wen, exp_wen[n]);
            // number and data only mean something when a write happens
            if (exp_wen[n]) begin
                check_reg($sformatf("commit %0d wnum", n), o_commit_rf_wnum, exp_wnum[n]);
                check_word($sformatf("commit %0d wdata", n), o_commit_rf_wdata,
                           exp_wdata[n]);
            end
        end

        // the commit after the last instruction comes from the model's next pc
        wait_commit(exp_pc.size());
        check_addr("pc after the last instruction", o_commit_pc, end_pc);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath widths
`define CORE_XLEN        32
`define CORE_REG_ADDR_W  5

// first fetch address out of reset
`define CORE_RESET_PC    32'h1c00_0000

// 3R format, opcode in inst[31:15]
`define CORE_OP_ADD_W    17'h00020
`define CORE_OP_SUB_W    17'h00022
`define CORE_OP_AND      17'h00029
`define CORE_OP_OR       17'h0002a
`define CORE_OP_XOR      17'h0002b

// immediate formats
`define CORE_OP_ADDI_W   10'h00a
`define CORE_OP_LU12I_W  7'h0a

// branches, opcode in inst[31:26]
`define CORE_OP_BEQ      6'h16
`define CORE_OP_BNE      6'h17
`define CORE_OP_B        6'h14

`endif

/* verilog/core_pkg.sv */
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    // one data word: instructions, operands, results
    typedef logic [`CORE_XLEN-1:0] word_t;

    // program counter values
    typedef logic [`CORE_XLEN-1:0] addr_t;

    // architectural register number
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // result is the shifted immediate
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_B,
        // unknown encodings retire without a write
        ALU_NOP
    } alu_op_e;

endpackage

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/100ps

`default_nettype none

module core_top (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    input  wire logic                i_ar_ready,
    input  wire logic                i_r_valid,
    input  wire core_pkg::word_t     i_r_data,
    output logic                     o_ar_valid,
    output core_pkg::addr_t          o_ar_addr,
    output logic                     o_r_ready,
    output logic                     o_commit_valid,
    output core_pkg::addr_t          o_commit_pc,
    output core_pkg::word_t          o_commit_inst,
    output logic                     o_commit_rf_wen,
    output core_pkg::reg_addr_t      o_commit_rf_wnum,
    output core_pkg::word_t          o_commit_rf_wdata
);

    // fetch to decode
    logic                f_valid;
    core_pkg::word_t     f_inst;
    core_pkg::addr_t     f_pc;
    logic                d_ready;

    // register file reads
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;

    // decode to execute
    logic                e_valid;
    core_pkg::alu_op_e   e_op;
    core_pkg::word_t     e_src_a;
    core_pkg::word_t     e_src_b;
    core_pkg::addr_t     e_target;
    core_pkg::reg_addr_t e_rd;
    core_pkg::addr_t     e_pc;
    core_pkg::word_t     e_inst;

    // redirect and writeback
    logic                redirect;
    core_pkg::addr_t     redirect_pc;
    logic                rf_we;
    core_pkg::reg_addr_t rf_waddr;
    core_pkg::word_t     rf_wdata;

    fetch_unit u_fetch (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_ar_ready    (i_ar_ready),
        .i_r_valid     (i_r_valid),
        .i_r_data      (i_r_data),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_ready       (d_ready),
        .o_ar_valid    (o_ar_valid),
        .o_ar_addr     (o_ar_addr),
        .o_r_ready     (o_r_ready),
        .o_valid       (f_valid),
        .o_inst        (f_inst),
        .o_pc          (f_pc)
    );

    decode_unit u_decode (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_valid    (f_valid),
        .i_inst     (f_inst),
        .i_pc       (f_pc),
        .i_flush    (redirect),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_wb_en    (rf_we),
        .i_wb_addr  (rf_waddr),
        .i_wb_data  (rf_wdata),
        .o_ready    (d_ready),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_valid    (e_valid),
        .o_op       (e_op),
        .o_src_a    (e_src_a),
        .o_src_b    (e_src_b),
        .o_target   (e_target),
        .o_rd       (e_rd),
        .o_pc       (e_pc),
        .o_inst     (e_inst)
    );

    register_file u_regfile (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_we       (rf_we),
        .i_waddr    (rf_waddr),
        .i_wdata    (rf_wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_unit u_execute (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_valid        (e_valid),
        .i_op           (e_op),
        .i_src_a        (e_src_a),
        .i_src_b        (e_src_b),
        .i_target       (e_target),
        .i_rd           (e_rd),
        .i_pc           (e_pc),
        .i_inst         (e_inst),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_rf_we        (rf_we),
        .o_rf_waddr     (rf_waddr),
        .o_rf_wdata     (rf_wdata),
        .o_commit_valid (o_commit_valid),
        .o_commit_pc    (o_commit_pc),
        .o_commit_inst  (o_commit_inst)
    );

    // commit trace shows the writeback of the retiring instruction
    assign o_commit_rf_wen   = rf_we;
    assign o_commit_rf_wnum  = rf_waddr;
    assign o_commit_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

/* verilog/decode_unit.sv */
`timescale 1ns/100ps

`include "core_cfg.svh"

`default_nettype none

module decode_unit (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    input  wire logic                i_valid,
    input  wire core_pkg::word_t     i_inst,
    input  wire core_pkg::addr_t     i_pc,
    input  wire logic                i_flush,
    input  wire core_pkg::word_t     i_rs1_data,
    input  wire core_pkg::word_t     i_rs2_data,
    input  wire logic                i_wb_en,
    input  wire core_pkg::reg_addr_t i_wb_addr,
    input  wire core_pkg::word_t     i_wb_data,
    output logic                     o_ready,
    output core_pkg::reg_addr_t      o_rs1_addr,
    output core_pkg::reg_addr_t      o_rs2_addr,
    output logic                     o_valid,
    output core_pkg::alu_op_e        o_op,
    output core_pkg::word_t          o_src_a,
    output core_pkg::word_t          o_src_b,
    output core_pkg::addr_t          o_target,
    output core_pkg::reg_addr_t      o_rd,
    output core_pkg::addr_t          o_pc,
    output core_pkg::word_t          o_inst
);

    logic                d_valid;
    core_pkg::word_t     d_inst;
    core_pkg::addr_t     d_pc;

    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rj;
    core_pkg::reg_addr_t rk;
    logic                is_cmp_br;
    core_pkg::word_t     rs1_val;
    core_pkg::word_t     rs2_val;
    core_pkg::word_t     imm_si12;
    core_pkg::word_t     imm_si20;
    core_pkg::word_t     offs16;
    core_pkg::word_t     offs26;

    // nothing new is taken while the pipeline is being redirected
    assign o_ready = ~i_flush;

    // execute never stalls, so the slot empties every cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= i_valid && o_ready;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_valid && o_ready) begin
            d_inst <= i_inst;
            d_pc   <= i_pc;
        end
    end

    assign rd = d_inst[4:0];
    assign rj = d_inst[9:5];
    assign rk = d_inst[14:10];

    assign is_cmp_br = (d_inst[31:26] == `CORE_OP_BEQ) || (d_inst[31:26] == `CORE_OP_BNE);

    // beq/bne compare rj against rd
    assign o_rs1_addr = rj;
    assign o_rs2_addr = is_cmp_br ? rd : rk;

    // bypass the result being written back this cycle
    assign rs1_val = (i_wb_en && (i_wb_addr == o_rs1_addr)) ? i_wb_data : i_rs1_data;
    assign rs2_val = (i_wb_en && (i_wb_addr == o_rs2_addr)) ? i_wb_data : i_rs2_data;

    assign imm_si12 = {{20{d_inst[21]}}, d_inst[21:10]};
    assign imm_si20 = {d_inst[24:5], 12'h000};
    assign offs16   = {{14{d_inst[25]}}, d_inst[25:10], 2'b00};
    assign offs26   = {{4{d_inst[9]}}, d_inst[9:0], d_inst[25:10], 2'b00};

    always_comb begin
        o_op     = core_pkg::ALU_NOP;
        o_src_b  = rs2_val;
        o_target = d_pc + offs16;
        if (d_inst[31:26] == `CORE_OP_BEQ) begin
            o_op = core_pkg::ALU_BEQ;
        end else if (d_inst[31:26] == `CORE_OP_BNE) begin
            o_op = core_pkg::ALU_BNE;
        end else if (d_inst[31:26] == `CORE_OP_B) begin
            o_op     = core_pkg::ALU_B;
            o_target = d_pc + offs26;
        end else if (d_inst[31:25] == `CORE_OP_LU12I_W) begin
            o_op    = core_pkg::ALU_LUI;
            o_src_b = imm_si20;
        end else if (d_inst[31:22] == `CORE_OP_ADDI_W) begin
            o_op    = core_pkg::ALU_ADD;
            o_src_b = imm_si12;
        end else begin
            case (d_inst[31:15])
                `CORE_OP_ADD_W: o_op = core_pkg::ALU_ADD;
                `CORE_OP_SUB_W: o_op = core_pkg::ALU_SUB;
                `CORE_OP_AND:   o_op = core_pkg::ALU_AND;
                `CORE_OP_OR:    o_op = core_pkg::ALU_OR;
                `CORE_OP_XOR:   o_op = core_pkg::ALU_XOR;
                default:        o_op = core_pkg::ALU_NOP;
            endcase
        end
    end

    // wrong-path instruction dies here on a redirect
    assign o_valid = d_valid & ~i_flush;
    assign o_src_a = rs1_val;
    assign o_rd    = rd;
    assign o_pc    = d_pc;
    assign o_inst  = d_inst;

endmodule

`default_nettype wire

/* verilog/execute_unit.sv */
`timescale 1ns/100ps

`default_nettype none

module execute_unit (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    input  wire logic                i_valid,
    input  wire core_pkg::alu_op_e   i_op,
    input  wire core_pkg::word_t     i_src_a,
    input  wire core_pkg::word_t     i_src_b,
    input  wire core_pkg::addr_t     i_target,
    input  wire core_pkg::reg_addr_t i_rd,
    input  wire core_pkg::addr_t     i_pc,
    input  wire core_pkg::word_t     i_inst,
    output logic                     o_redirect,
    output core_pkg::addr_t          o_redirect_pc,
    output logic                     o_rf_we,
    output core_pkg::reg_addr_t      o_rf_waddr,
    output core_pkg::word_t          o_rf_wdata,
    output logic                     o_commit_valid,
    output core_pkg::addr_t          o_commit_pc,
    output core_pkg::word_t          o_commit_inst
);

    logic                e_valid;
    core_pkg::alu_op_e   e_op;
    core_pkg::word_t     e_src_a;
    core_pkg::word_t     e_src_b;
    core_pkg::addr_t     e_target;
    core_pkg::reg_addr_t e_rd;
    core_pkg::addr_t     e_pc;
    core_pkg::word_t     e_inst;

    core_pkg::word_t     alu_result;
    logic                is_alu;
    logic                taken;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_valid) begin
            e_op     <= i_op;
            e_src_a  <= i_src_a;
            e_src_b  <= i_src_b;
            e_target <= i_target;
            e_rd     <= i_rd;
            e_pc     <= i_pc;
            e_inst   <= i_inst;
        end
    end

    always_comb begin
        alu_result = '0;
        is_alu     = 1'b1;
        taken      = 1'b0;
        case (e_op)
            core_pkg::ALU_ADD: alu_result = e_src_a + e_src_b;
            core_pkg::ALU_SUB: alu_result = e_src_a - e_src_b;
            core_pkg::ALU_AND: alu_result = e_src_a & e_src_b;
            core_pkg::ALU_OR:  alu_result = e_src_a | e_src_b;
            core_pkg::ALU_XOR: alu_result = e_src_a ^ e_src_b;
            core_pkg::ALU_LUI: alu_result = e_src_b;
            core_pkg::ALU_BEQ: begin
                is_alu = 1'b0;
                taken  = (e_src_a == e_src_b);
            end
            core_pkg::ALU_BNE: begin
                is_alu = 1'b0;
                taken  = (e_src_a != e_src_b);
            end
            core_pkg::ALU_B: begin
                is_alu = 1'b0;
                taken  = 1'b1;
            end
            default: is_alu = 1'b0;
        endcase
    end

    // fetch already runs sequentially, so a jump to pc+4 needs no flush
    assign o_redirect    = e_valid && taken && (e_target != e_pc + 32'd4);
    assign o_redirect_pc = e_target;

    assign o_rf_we    = e_valid && is_alu && (e_rd != '0);
    assign o_rf_waddr = e_rd;
    assign o_rf_wdata = alu_result;

    assign o_commit_valid = e_valid;
    assign o_commit_pc    = e_pc;
    assign o_commit_inst  = e_inst;

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/100ps

`include "core_cfg.svh"

`default_nettype none

module fetch_unit (
    input  wire logic            aclk,
    input  wire logic            aresetn,
    input  wire logic            i_ar_ready,
    input  wire logic            i_r_valid,
    input  wire core_pkg::word_t i_r_data,
    input  wire logic            i_redirect,
    input  wire core_pkg::addr_t i_redirect_pc,
    input  wire logic            i_ready,
    output logic                 o_ar_valid,
    output core_pkg::addr_t      o_ar_addr,
    output logic                 o_r_ready,
    output logic                 o_valid,
    output core_pkg::word_t      o_inst,
    output core_pkg::addr_t      o_pc
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e    state;
    core_pkg::addr_t pc;
    core_pkg::addr_t ar_addr;
    logic            stale;
    logic            hold_valid;
    core_pkg::word_t hold_inst;
    core_pkg::addr_t hold_pc;

    logic            ar_hs;
    logic            r_hs;
    logic            keep_resp;
    logic            can_issue;
    logic            issue;
    core_pkg::addr_t issue_pc;

    assign ar_hs     = (state == FETCH_REQ) && i_ar_ready;
    assign r_hs      = (state == FETCH_WAIT) && i_r_valid;
    // responses from a flushed path are accepted and dropped
    assign keep_resp = r_hs && !stale && !i_redirect;
    // holding register empty, or drained or flushed this cycle
    assign can_issue = !hold_valid || i_ready || i_redirect;
    // after a kept response the holding register is full, so wait in idle
    assign issue     = (state == FETCH_IDLE) ? can_issue : (r_hs && !keep_resp);
    assign issue_pc  = i_redirect ? i_redirect_pc : pc;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= FETCH_IDLE;
            pc         <= `CORE_RESET_PC;
            stale      <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            // redirect beats sequential stepping
            if (i_redirect) begin
                pc <= i_redirect_pc;
            end else if (ar_hs && !stale) begin
                pc <= pc + 32'd4;
            end

            case (state)
                FETCH_IDLE: begin
                    if (issue) begin
                        state <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (i_redirect) begin
                        stale <= 1'b1;
                    end
                    if (ar_hs) begin
                        state <= FETCH_WAIT;
                    end
                end
                default: begin
                    if (r_hs) begin
                        stale <= 1'b0;
                        state <= issue ? FETCH_REQ : FETCH_IDLE;
                    end else if (i_redirect) begin
                        stale <= 1'b1;
                    end
                end
            endcase

            if (i_redirect) begin
                hold_valid <= 1'b0;
            end else if (keep_resp) begin
                hold_valid <= 1'b1;
            end else if (i_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (issue) begin
            ar_addr <= issue_pc;
        end
        // ar_addr still names the outstanding request here
        if (keep_resp) begin
            hold_inst <= i_r_data;
            hold_pc   <= ar_addr;
        end
    end

    assign o_ar_valid = (state == FETCH_REQ);
    assign o_ar_addr  = ar_addr;
    assign o_r_ready  = (state == FETCH_WAIT);
    assign o_valid    = hold_valid;
    assign o_inst     = hold_inst;
    assign o_pc       = hold_pc;

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/100ps

`default_nettype none

module register_file (
    input  wire logic                aclk,
    input  wire logic                aresetn,
    input  wire core_pkg::reg_addr_t i_rs1_addr,
    input  wire core_pkg::reg_addr_t i_rs2_addr,
    input  wire logic                i_we,
    input  wire core_pkg::reg_addr_t i_waddr,
    input  wire core_pkg::word_t     i_wdata,
    output core_pkg::word_t          o_rs1_data,
    output core_pkg::word_t          o_rs2_data
);

    // r1..r31, r0 has no storage
    core_pkg::word_t regs [1:31];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire
